// ==== design/layer_cfg_pkg.sv ====
package layer_cfg_pkg;

    ////////////////////
    // Register map
    ////////////////////
    localparam logic [3:0] REG_CTRL0   = 4'd0;  // Mode and enable
    localparam logic [3:0] REG_CTRL1   = 4'd1;  // Map height and width
    localparam logic [3:0] REG_MAP_LO  = 4'd2;
    localparam logic [3:0] REG_MAP_HI  = 4'd3;
    localparam logic [3:0] REG_TILE_LO = 4'd4;
    localparam logic [3:0] REG_TILE_HI = 4'd5;
    localparam logic [3:0] REG_HSCR_LO = 4'd6;
    localparam logic [3:0] REG_HSCR_HI = 4'd7;
    localparam logic [3:0] REG_VSCR_LO = 4'd8;
    localparam logic [3:0] REG_VSCR_HI = 4'd9;

    localparam logic [15:0] TILE_BASE_RESET = 16'h8000;

    ////////////////////
    // Mode fields
    ////////////////////
    typedef enum logic [2:0] {
        MODE_TILE_2BPP = 3'd2,
        MODE_TILE_4BPP = 3'd3,
        MODE_TILE_8BPP = 3'd4,
        MODE_BMP_2BPP  = 3'd5,
        MODE_BMP_4BPP  = 3'd6,
        MODE_BMP_8BPP  = 3'd7
    } layer_mode_t;

    typedef enum logic [1:0] {DEPTH_2, DEPTH_4, DEPTH_8} color_depth_t;

    typedef enum logic [1:0] {SIZE_32, SIZE_64, SIZE_128, SIZE_256} map_size_t;

    function automatic color_depth_t mode_depth(layer_mode_t m);
        case (m)
            MODE_TILE_4BPP, MODE_BMP_4BPP: return DEPTH_4;
            MODE_TILE_8BPP, MODE_BMP_8BPP: return DEPTH_8;
            default: return DEPTH_2;
        endcase
    endfunction

    function automatic logic mode_is_bitmap(layer_mode_t m);
        return m >= MODE_BMP_2BPP;
    endfunction

endpackage

// ==== design/layer_bus_pkg.sv ====
package layer_bus_pkg;

    typedef logic [15:0] bus_addr_t;   // Word address
    typedef logic [31:0] bus_data_t;
    typedef logic [7:0]  pixel_t;      // Color index
    typedef logic [9:0]  lb_idx_t;     // Line buffer slot, wraps below zero
    typedef logic [11:0] scroll_t;

    localparam int LINE_PIXELS = 640;

endpackage

// ==== design/layer_regs.sv ====
module layer_regs (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [3:0]                regs_addr,
    input  logic [7:0]                regs_wrdata,
    input  logic                      regs_write,
    output logic [7:0]                regs_rddata,
    output logic                      layer_enabled,
    output layer_cfg_pkg::layer_mode_t mode,
    output layer_cfg_pkg::map_size_t  map_width,
    output layer_cfg_pkg::map_size_t  map_height,
    output layer_bus_pkg::bus_addr_t  map_base,
    output layer_bus_pkg::bus_addr_t  tile_base,
    output layer_bus_pkg::scroll_t    hscroll,
    output layer_bus_pkg::scroll_t    vscroll
);
    import layer_cfg_pkg::*;

    // Readback, unused bits as zero
    always_comb begin
        case (regs_addr)
            REG_CTRL0:   regs_rddata = {mode, 4'b0000, layer_enabled};
            REG_CTRL1:   regs_rddata = {4'b0000, map_height, map_width};
            REG_MAP_LO:  regs_rddata = map_base[7:0];
            REG_MAP_HI:  regs_rddata = map_base[15:8];
            REG_TILE_LO: regs_rddata = tile_base[7:0];
            REG_TILE_HI: regs_rddata = tile_base[15:8];
            REG_HSCR_LO: regs_rddata = hscroll[7:0];
            REG_HSCR_HI: regs_rddata = {4'b0000, hscroll[11:8]};
            REG_VSCR_LO: regs_rddata = vscroll[7:0];
            REG_VSCR_HI: regs_rddata = {4'b0000, vscroll[11:8]};
            default:     regs_rddata = 8'h00;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mode          <= MODE_TILE_2BPP;
            layer_enabled <= 1'b0;
            map_width     <= SIZE_32;
            map_height    <= SIZE_32;
            map_base      <= '0;
            tile_base     <= TILE_BASE_RESET;
            hscroll       <= '0;
            vscroll       <= '0;
        end else if (regs_write) begin
            case (regs_addr)
                REG_CTRL0: begin
                    // Text modes 0 and 1 fall back to 2 bpp tiles
                    mode <= (regs_wrdata[7:5] < 3'd2) ? MODE_TILE_2BPP
                                                      : layer_mode_t'(regs_wrdata[7:5]);
                    layer_enabled <= regs_wrdata[0];
                end
                REG_CTRL1: begin
                    map_height <= map_size_t'(regs_wrdata[3:2]);
                    map_width  <= map_size_t'(regs_wrdata[1:0]);
                end
                REG_MAP_LO:  map_base[7:0]   <= regs_wrdata;
                REG_MAP_HI:  map_base[15:8]  <= regs_wrdata;
                REG_TILE_LO: tile_base[7:0]  <= regs_wrdata;
                REG_TILE_HI: tile_base[15:8] <= regs_wrdata;
                REG_HSCR_LO: hscroll[7:0]    <= regs_wrdata;
                REG_HSCR_HI: hscroll[11:8]   <= regs_wrdata[3:0];
                REG_VSCR_LO: vscroll[7:0]    <= regs_wrdata;
                REG_VSCR_HI: vscroll[11:8]   <= regs_wrdata[3:0];
                default: ;
            endcase
        end
    end

    // Host must not put unknown data on the port, even outside the map
    a_wr_known: assert property (@(posedge clk) disable iff (rst)
        (regs_write && regs_addr > REG_VSCR_HI) |-> !$isunknown(regs_wrdata));

endmodule

// ==== design/layer_addr_gen.sv ====
module layer_addr_gen (
    input  layer_cfg_pkg::layer_mode_t mode,
    input  layer_cfg_pkg::map_size_t  map_width,
    input  layer_cfg_pkg::map_size_t  map_height,
    input  layer_bus_pkg::bus_addr_t  map_base,
    input  layer_bus_pkg::bus_addr_t  tile_base,
    input  layer_bus_pkg::scroll_t    hscroll,
    input  layer_bus_pkg::scroll_t    vscroll,
    input  logic [8:0]                line_idx,
    input  logic [7:0]                htile_cnt,
    input  logic                      word_cnt,
    input  layer_bus_pkg::bus_data_t  map_word,
    output layer_bus_pkg::bus_addr_t  map_addr,
    output layer_bus_pkg::bus_addr_t  tile_addr,
    output layer_bus_pkg::bus_addr_t  bitmap_line_addr,
    output logic                      line_sel,
    output logic                      tile_hflip,
    output logic [3:0]                tile_palette
);
    import layer_cfg_pkg::*;

    color_depth_t depth;
    logic [11:0]  scrolled_line;
    logic [7:0]   vmap, hmap, row, col;
    logic [15:0]  map_idx, tile_off, bmp_off;
    logic [15:0]  map_half;
    logic [2:0]   fine_line;
    logic [11:0]  line_x5;

    assign depth         = mode_depth(mode);
    assign scrolled_line = {3'b000, line_idx} + vscroll;
    assign vmap          = scrolled_line[10:3];
    assign hmap          = htile_cnt + hscroll[10:3];

    ////////////////////
    // Map wrap
    ////////////////////
    always_comb begin
        case (map_height)
            SIZE_32:  row = {3'b000, vmap[4:0]};
            SIZE_64:  row = {2'b00, vmap[5:0]};
            SIZE_128: row = {1'b0, vmap[6:0]};
            default:  row = vmap;
        endcase
        case (map_width)
            SIZE_32:  map_idx = {3'b000, row, hmap[4:0]};
            SIZE_64:  map_idx = {2'b00, row, hmap[5:0]};
            SIZE_128: map_idx = {1'b0, row, hmap[6:0]};
            default:  map_idx = {row, hmap};
        endcase
    end

    assign col      = hmap;  // Low bit picks the map halfword
    assign map_addr = map_base + {1'b0, map_idx[15:1]};
    assign map_half = col[0] ? map_word[31:16] : map_word[15:0];

    assign tile_hflip   = map_half[10];
    assign tile_palette = map_half[15:12];
    assign fine_line    = map_half[11] ? ~scrolled_line[2:0] : scrolled_line[2:0];
    assign line_sel     = fine_line[0];  // Two lines per word at 2 bpp

    ////////////////////
    // Tile and bitmap
    ////////////////////
    always_comb begin
        case (depth)
            DEPTH_8: tile_off = {2'b00, map_half[9:0], fine_line, word_cnt ^ tile_hflip};
            DEPTH_4: tile_off = {3'b000, map_half[9:0], fine_line};
            default: tile_off = {4'b0000, map_half[9:0], fine_line[2:1]};
        endcase
    end

    assign tile_addr = tile_base + tile_off;
    assign line_x5   = {3'b000, line_idx} + {1'b0, line_idx, 2'b00};

    always_comb begin
        case (depth)
            DEPTH_8: bmp_off = {1'b0, line_x5, 3'b000};
            DEPTH_4: bmp_off = {2'b00, line_x5, 2'b00};
            default: bmp_off = {3'b000, line_x5, 1'b0};
        endcase
    end

    assign bitmap_line_addr = tile_base + bmp_off;

endmodule

// ==== design/layer_fetch.sv ====
module layer_fetch (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      line_render_start,
    input  layer_cfg_pkg::layer_mode_t mode,
    input  layer_bus_pkg::scroll_t    hscroll,
    input  layer_bus_pkg::bus_addr_t  map_addr,
    input  layer_bus_pkg::bus_addr_t  tile_addr,
    input  layer_bus_pkg::bus_addr_t  bitmap_line_addr,
    input  logic                      line_sel,
    input  logic                      tile_hflip,
    input  logic [3:0]                tile_palette,
    input  layer_bus_pkg::bus_data_t  bus_rddata,
    input  logic                      bus_ack,
    input  logic                      render_busy,
    input  logic                      line_done,
    output layer_bus_pkg::bus_addr_t  bus_addr,
    output logic                      bus_strobe,
    output logic [7:0]                htile_cnt,
    output logic                      word_cnt,
    output layer_bus_pkg::bus_data_t  map_word,
    output logic                      render_start,
    output layer_bus_pkg::bus_data_t  render_data,
    output logic [7:0]                render_attr
);
    import layer_cfg_pkg::*;
    import layer_bus_pkg::*;

    typedef enum logic [2:0] {
        WAIT_START, FETCH_MAP, WAIT_FETCH_MAP, FETCH_TILE, WAIT_FETCH_TILE, RENDER
    } fetch_state_t;

    fetch_state_t state;
    logic         strobe_r;
    bus_addr_t    bitmap_addr;
    bus_data_t    tile_data;
    logic         bitmap;
    logic         last_word;
    logic         col_odd;

    assign bitmap     = mode_is_bitmap(mode);
    assign last_word  = (mode_depth(mode) != DEPTH_8) || word_cnt;  // 8 bpp takes 2 words
    assign col_odd    = htile_cnt[0] ^ hscroll[3];
    assign bus_strobe = strobe_r & ~bus_ack;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= WAIT_START;
            strobe_r     <= 1'b0;
            bus_addr     <= '0;
            bitmap_addr  <= '0;
            htile_cnt    <= '0;
            word_cnt     <= 1'b0;
            map_word     <= '0;
            tile_data    <= '0;
            render_start <= 1'b0;
            render_data  <= '0;
            render_attr  <= '0;
        end else begin
            render_start <= 1'b0;
            case (state)
                FETCH_MAP: begin
                    bus_addr <= map_addr;
                    strobe_r <= 1'b1;
                    state    <= WAIT_FETCH_MAP;
                end
                WAIT_FETCH_MAP: if (bus_ack) begin
                    map_word <= bus_rddata;
                    strobe_r <= 1'b0;
                    state    <= FETCH_TILE;
                end
                FETCH_TILE: begin
                    bus_addr    <= bitmap ? bitmap_addr : tile_addr;
                    bitmap_addr <= bitmap_addr + 16'd1;
                    strobe_r    <= 1'b1;
                    state       <= WAIT_FETCH_TILE;
                end
                WAIT_FETCH_TILE: if (bus_ack) begin
                    tile_data <= bus_rddata;
                    strobe_r  <= 1'b0;
                    state     <= RENDER;
                end
                RENDER: begin
                    if (!render_busy) begin
                        // 2 bpp tile line is one half of the word
                        if (mode == MODE_TILE_2BPP)
                            render_data <= {16'h0000,
                                            line_sel ? tile_data[31:16] : tile_data[15:0]};
                        else
                            render_data <= tile_data;
                        render_attr  <= bitmap ? {hscroll[11:8], 4'b0000}
                                               : {tile_palette, 3'b000, tile_hflip};
                        render_start <= 1'b1;
                        state        <= FETCH_TILE;
                        if (!bitmap) begin
                            if (last_word) begin
                                word_cnt  <= 1'b0;
                                htile_cnt <= htile_cnt + 8'd1;
                                if (col_odd)
                                    state <= FETCH_MAP;  // Map word holds 2 entries
                            end else begin
                                word_cnt <= 1'b1;
                            end
                        end
                    end
                    if (line_done)
                        state <= WAIT_START;
                end
                default: ;
            endcase

            if (line_render_start) begin
                htile_cnt <= '0;
                word_cnt  <= 1'b0;
                if (bitmap) begin
                    // No map for bitmaps, first word goes out at once
                    bus_addr    <= bitmap_line_addr;
                    bitmap_addr <= bitmap_line_addr + 16'd1;
                    strobe_r    <= 1'b1;
                    state       <= WAIT_FETCH_TILE;
                end else begin
                    state <= FETCH_MAP;
                end
            end
        end
    end

    a_addr_hold: assert property (@(posedge clk) disable iff (rst)
        (bus_strobe && !line_render_start) |=> $stable(bus_addr));

endmodule

// ==== design/layer_pixel_out.sv ====
module layer_pixel_out #(
    parameter int LINE_PIXELS = layer_bus_pkg::LINE_PIXELS
) (
    input  logic                      clk,
    input  logic                      rst,
    input  layer_cfg_pkg::layer_mode_t mode,
    input  layer_bus_pkg::scroll_t    hscroll,
    input  logic                      line_render_start,
    input  logic                      render_start,
    input  layer_bus_pkg::bus_data_t  render_data,
    input  logic [7:0]                render_attr,
    output logic                      render_busy,
    output logic                      line_done,
    output layer_bus_pkg::lb_idx_t    linebuf_wridx,
    output layer_bus_pkg::pixel_t     linebuf_wrdata,
    output logic                      linebuf_wren
);
    import layer_cfg_pkg::*;
    import layer_bus_pkg::*;

    color_depth_t depth;
    logic [3:0]   xcnt, xcnt_next, ppw_m1, hx;
    logic         busy_r, busy_next, wren_next, reach;
    lb_idx_t      wr_idx, idx_next, idx_start;
    pixel_t       raw, pixel;

    assign depth = mode_depth(mode);
    assign reach = (wr_idx == lb_idx_t'(LINE_PIXELS));

    always_comb begin
        case (depth)
            DEPTH_8: ppw_m1 = 4'd3;
            DEPTH_4: ppw_m1 = 4'd7;
            default: ppw_m1 = mode_is_bitmap(mode) ? 4'd15 : 4'd7;
        endcase
    end

    ////////////////////
    // Pixel select
    ////////////////////
    assign hx = render_attr[0] ? (xcnt ^ ppw_m1) : xcnt;  // H-flip

    // Bytes ascending, MSB first within a byte
    always_comb begin
        case (depth)
            DEPTH_8: raw = render_data[{hx[1:0], 3'b000} +: 8];
            DEPTH_4: raw = {4'b0000, render_data[{hx[2:1], ~hx[0], 2'b00} +: 4]};
            default: raw = {6'b000000, render_data[{hx[3:2], ~hx[1:0], 1'b0} +: 2]};
        endcase
    end

    // Palette offset on low nonzero colors
    assign pixel = (raw[7:4] == 4'h0 && raw[3:0] != 4'h0) ? {render_attr[7:4], raw[3:0]} : raw;

    assign idx_start = mode_is_bitmap(mode) ? '0 : 10'd0 - {7'd0, hscroll[2:0]};

    always_comb begin
        xcnt_next = xcnt;
        busy_next = busy_r;
        idx_next  = wr_idx;
        wren_next = 1'b0;
        if (!reach && (busy_r || render_start)) begin
            if (xcnt == ppw_m1) begin
                xcnt_next = '0;
                busy_next = 1'b0;
            end else begin
                xcnt_next = xcnt + 4'd1;
                busy_next = 1'b1;
            end
            wren_next = 1'b1;
            idx_next  = wr_idx + 10'd1;
        end
        if (line_render_start) begin
            xcnt_next = '0;
            busy_next = 1'b0;
            idx_next  = idx_start;  // Sub-tile scroll
        end
    end

    assign render_busy = busy_next;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            xcnt         <= '0;
            busy_r       <= 1'b0;
            wr_idx       <= '0;
            linebuf_wren <= 1'b0;
            line_done    <= 1'b0;
        end else begin
            xcnt         <= xcnt_next;
            busy_r       <= busy_next;
            wr_idx       <= idx_next;
            linebuf_wren <= wren_next;
            line_done    <= line_render_start ? 1'b0 : reach;
        end
    end

    always_ff @(posedge clk) begin
        if (wren_next) begin
            linebuf_wridx  <= wr_idx;
            linebuf_wrdata <= pixel;
        end
    end

    // Done only rises after the last write has left
    a_no_wr_done: assert property (@(posedge clk) disable iff (rst)
        linebuf_wren |-> !line_done);

endmodule

// ==== design/layer_renderer.sv ====
module layer_renderer #(
    parameter int LINE_PIXELS = layer_bus_pkg::LINE_PIXELS
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [8:0]               line_idx,
    input  logic                     line_render_start,
    output logic                     line_render_done,
    output logic                     layer_enabled,
    input  logic [3:0]               regs_addr,
    input  logic [7:0]               regs_wrdata,
    output logic [7:0]               regs_rddata,
    input  logic                     regs_write,
    output layer_bus_pkg::bus_addr_t bus_addr,
    input  layer_bus_pkg::bus_data_t bus_rddata,
    output logic                     bus_strobe,
    input  logic                     bus_ack,
    output layer_bus_pkg::lb_idx_t   linebuf_wridx,
    output layer_bus_pkg::pixel_t    linebuf_wrdata,
    output logic                     linebuf_wren
);
    import layer_cfg_pkg::*;
    import layer_bus_pkg::*;

    // Configuration
    layer_mode_t mode;
    map_size_t   map_width, map_height;
    bus_addr_t   map_base, tile_base;
    scroll_t     hscroll, vscroll;

    // Fetch addressing
    bus_addr_t   map_addr, tile_addr, bitmap_line_addr;
    logic        line_sel, tile_hflip;
    logic [3:0]  tile_palette;
    logic [7:0]  htile_cnt;
    logic        word_cnt;
    bus_data_t   map_word;

    // Fetch to pixel output
    logic        render_start, render_busy;
    bus_data_t   render_data;
    logic [7:0]  render_attr;

    layer_regs u_regs (
        .clk, .rst, .regs_addr, .regs_wrdata, .regs_write, .regs_rddata,
        .layer_enabled, .mode, .map_width, .map_height,
        .map_base, .tile_base, .hscroll, .vscroll
    );

    layer_addr_gen u_addr_gen (
        .mode, .map_width, .map_height, .map_base, .tile_base, .hscroll, .vscroll,
        .line_idx, .htile_cnt, .word_cnt, .map_word,
        .map_addr, .tile_addr, .bitmap_line_addr, .line_sel, .tile_hflip, .tile_palette
    );

    layer_fetch u_fetch (
        .clk, .rst, .line_render_start, .mode, .hscroll,
        .map_addr, .tile_addr, .bitmap_line_addr, .line_sel, .tile_hflip, .tile_palette,
        .bus_rddata, .bus_ack, .render_busy,
        .line_done (line_render_done),
        .bus_addr, .bus_strobe, .htile_cnt, .word_cnt, .map_word,
        .render_start, .render_data, .render_attr
    );

    layer_pixel_out #(
        .LINE_PIXELS (LINE_PIXELS)
    ) u_pixel_out (
        .clk, .rst, .mode, .hscroll, .line_render_start,
        .render_start, .render_data, .render_attr, .render_busy,
        .line_done (line_render_done),
        .linebuf_wridx, .linebuf_wrdata, .linebuf_wren
    );

endmodule

// ==== bench/layer_checker.sv ====
module layer_checker (
    input  logic                   clk,
    input  logic [7:0]             regs_rddata,
    input  logic                   layer_enabled,
    input  logic                   line_render_done,
    input  logic                   bus_strobe,
    input  logic                   linebuf_wren,
    input  layer_bus_pkg::lb_idx_t linebuf_wridx,
    input  layer_bus_pkg::pixel_t  linebuf_wrdata
);
    int errors = 0;
    int tests = 0;
    int failed = 0;
    int test_err = 0;

    // Line under test
    logic [2:0]  m_mode;
    logic [3:0]  m_size;  // Height in 3:2, width in 1:0
    logic [15:0] m_map, m_tile;
    logic [11:0] m_hs, m_vs;
    logic [8:0]  m_line;

    logic [7:0]  got_px [640];
    int          hits [640];

    always @(negedge clk) begin
        if (linebuf_wren === 1'b1 && linebuf_wridx < 10'd640) begin
            hits[linebuf_wridx]++;
            got_px[linebuf_wridx] = linebuf_wrdata;
        end
    end

    task automatic report_error(input string name, input logic [7:0] got, input logic [7:0] exp);
        errors++;
        test_err++;
        $display("ERROR t=%0t %s: got %h expected %h", $time, name, got, exp);
    endtask

    task automatic compare_reg(input string name, input logic [7:0] exp);
        if (regs_rddata !== exp)
            report_error(name, regs_rddata, exp);
    endtask

    task automatic compare_enable(input logic exp);
        if (layer_enabled !== exp)
            report_error("layer_enabled", {7'd0, layer_enabled}, {7'd0, exp});
    endtask

    task automatic check_outputs_low();
        if (line_render_done !== 1'b0)
            report_error("line_render_done", {7'd0, line_render_done}, 8'h00);
        if (bus_strobe !== 1'b0)
            report_error("bus_strobe", {7'd0, bus_strobe}, 8'h00);
        if (linebuf_wren !== 1'b0)
            report_error("linebuf_wren", {7'd0, linebuf_wren}, 8'h00);
        compare_enable(1'b0);
    endtask

    ////////////////////
    // Reference model
    ////////////////////
    function automatic logic [7:0] model_pixel(input int x);
        int          bpp, j, shift, p, t, q, col, row, idx, fine, wd, ht;
        logic [15:0] addr, half;
        logic [31:0] word, mword;
        logic [3:0]  pal;
        logic [7:0]  raw;
        bpp = (m_mode == 3'd4 || m_mode == 3'd7) ? 8 : (m_mode == 3'd3 || m_mode == 3'd6) ? 4 : 2;
        if (m_mode >= 3'd5) begin
            addr = 16'(int'(m_tile) + int'(m_line) * 5 * bpp + x / (32 / bpp));
            word = tb_layer_renderer.mem[addr];
            j = x % (32 / bpp);
            pal = m_hs[11:8];  // Bitmap palette from hscroll
        end else begin
            wd = 32 << m_size[1:0];
            ht = 32 << m_size[3:2];
            p = x + int'(m_hs[2:0]);
            t = p / 8;
            q = p % 8;
            col = ((t + int'(m_hs[10:3])) % 256) % wd;
            row = (((int'(m_line) + int'(m_vs)) % 4096) / 8) % ht;
            idx = row * wd + col;
            mword = tb_layer_renderer.mem[16'(int'(m_map) + idx / 2)];
            half = (idx % 2 == 1) ? mword[31:16] : mword[15:0];
            fine = (int'(m_line) + int'(m_vs)) % 8;
            if (half[11])
                fine = 7 - fine;  // V-flip
            if (half[10])
                q = 7 - q;        // H-flip
            pal = half[15:12];
            if (bpp == 8)
                addr = 16'(int'(m_tile) + int'(half[9:0]) * 16 + fine * 2 + q / 4);
            else if (bpp == 4)
                addr = 16'(int'(m_tile) + int'(half[9:0]) * 8 + fine);
            else
                addr = 16'(int'(m_tile) + int'(half[9:0]) * 4 + fine / 2);
            word = tb_layer_renderer.mem[addr];
            if (bpp == 2 && fine % 2 == 1)
                word = word >> 16;  // Odd line in upper half
            j = (bpp == 8) ? q % 4 : q;
        end
        if (bpp == 8)
            shift = j * 8;
        else if (bpp == 4)
            shift = (j / 2) * 8 + ((j % 2 == 0) ? 4 : 0);
        else
            shift = (j / 4) * 8 + (3 - j % 4) * 2;
        raw = 8'((word >> shift) & ((32'd1 << bpp) - 32'd1));
        if (raw != 8'd0 && raw < 8'd16)
            raw = {pal, raw[3:0]};
        return raw;
    endfunction

    task automatic start_line(input logic [2:0] mode, input logic [3:0] size,
                              input logic [15:0] map_base, input logic [15:0] tile_base,
                              input logic [11:0] hs, input logic [11:0] vs,
                              input logic [8:0] line);
        m_mode = mode;
        m_size = size;
        m_map  = map_base;
        m_tile = tile_base;
        m_hs   = hs;
        m_vs   = vs;
        m_line = line;
        for (int i = 0; i < 640; i++)
            hits[i] = 0;
    endtask

    task automatic finish_line();
        for (int i = 0; i < 640; i++) begin
            if (hits[i] != 1) begin
                errors++;
                test_err++;
                $display("Pixel %0d written %0d times, expected once", i, hits[i]);
            end else if (got_px[i] !== model_pixel(i)) begin
                report_error($sformatf("linebuf_wrdata[%0d]", i), got_px[i], model_pixel(i));
            end
        end
    endtask

    task automatic close_test(input string name);
        tests++;
        if (test_err != 0)
            failed++;
        $display("%s: %s (%0d errors)", name, (test_err == 0) ? "pass" : "fail", test_err);
        test_err = 0;
    endtask

    task automatic print_counts();
        $display("%0d tests run, %0d failed, %0d errors", tests, failed, errors);
    endtask

endmodule

// ==== bench/tb_layer_renderer.sv ====
module tb_layer_renderer;
    import layer_bus_pkg::*;

    localparam int NUM_ROWS    = 9;
    localparam int CYCLE_LIMIT = NUM_ROWS * 5000;

    typedef struct packed {
        logic [7:0]  ctrl0_wr;
        logic [7:0]  ctrl0_exp;
        logic [7:0]  ctrl1_wr;
        logic [15:0] map_base;
        logic [15:0] tile_base;
        logic [15:0] hscr;   // Upper nibble of each byte pair is junk
        logic [15:0] vscr;
        logic [8:0]  line;
    } row_t;

    logic        clk = 1'b0;
    logic        rst;
    logic [8:0]  line_idx;
    logic        line_render_start, line_render_done, layer_enabled;
    logic [3:0]  regs_addr;
    logic [7:0]  regs_wrdata, regs_rddata;
    logic        regs_write;
    bus_addr_t   bus_addr;
    bus_data_t   bus_rddata = '0;
    logic        bus_strobe;
    logic        bus_ack = 1'b0;
    lb_idx_t     linebuf_wridx;
    pixel_t      linebuf_wrdata;
    logic        linebuf_wren;

    logic [31:0] mem [0:65535];
    row_t        rows [NUM_ROWS];
    int          cycles = 0;
    logic        pending = 1'b0;
    int          ack_wait = 0;

    always #10 clk = ~clk;

    layer_renderer uut (
        .clk, .rst, .line_idx, .line_render_start, .line_render_done, .layer_enabled,
        .regs_addr, .regs_wrdata, .regs_rddata, .regs_write,
        .bus_addr, .bus_rddata, .bus_strobe, .bus_ack,
        .linebuf_wridx, .linebuf_wrdata, .linebuf_wren
    );

    layer_checker chk (
        .clk, .regs_rddata, .layer_enabled, .line_render_done, .bus_strobe,
        .linebuf_wren, .linebuf_wridx, .linebuf_wrdata
    );

    ////////////////////
    // Bus memory
    ////////////////////
    always begin
        @(posedge clk);
        #2;
        if (bus_ack) begin
            bus_ack = 1'b0;
        end else if (bus_strobe) begin
            if (!pending) begin
                pending  = 1'b1;
                ack_wait = int'($urandom % 4);  // 0 to 3 extra cycles
            end
            if (ack_wait == 0) begin
                bus_ack    = 1'b1;
                bus_rddata = mem[bus_addr];
                pending    = 1'b0;
            end else begin
                ack_wait--;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: line render did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic write_reg(input logic [3:0] addr, input logic [7:0] data);
        @(posedge clk);
        #2;
        regs_addr   = addr;
        regs_wrdata = data;
        regs_write  = 1'b1;
        @(posedge clk);
        #2;
        regs_write = 1'b0;
    endtask

    task automatic check_readback(input logic [3:0] addr, input logic [7:0] exp,
                                  input string name);
        @(posedge clk);
        #2;
        regs_addr = addr;
        @(negedge clk);
        chk.compare_reg(name, exp);
    endtask

    task automatic render_row(input int r);
        row_t rw;
        rw = rows[r];
        write_reg(4'd0, rw.ctrl0_wr);
        write_reg(4'd1, rw.ctrl1_wr);
        write_reg(4'd2, rw.map_base[7:0]);
        write_reg(4'd3, rw.map_base[15:8]);
        write_reg(4'd4, rw.tile_base[7:0]);
        write_reg(4'd5, rw.tile_base[15:8]);
        write_reg(4'd6, rw.hscr[7:0]);
        write_reg(4'd7, rw.hscr[15:8]);
        write_reg(4'd8, rw.vscr[7:0]);
        write_reg(4'd9, rw.vscr[15:8]);
        check_readback(4'd0, rw.ctrl0_exp, "regs_rddata CTRL0");
        check_readback(4'd1, {4'h0, rw.ctrl1_wr[3:0]}, "regs_rddata CTRL1");
        check_readback(4'd2, rw.map_base[7:0], "regs_rddata MAP_LO");
        check_readback(4'd3, rw.map_base[15:8], "regs_rddata MAP_HI");
        check_readback(4'd4, rw.tile_base[7:0], "regs_rddata TILE_LO");
        check_readback(4'd5, rw.tile_base[15:8], "regs_rddata TILE_HI");
        check_readback(4'd6, rw.hscr[7:0], "regs_rddata HSCR_LO");
        check_readback(4'd7, {4'h0, rw.hscr[11:8]}, "regs_rddata HSCR_HI");
        check_readback(4'd8, rw.vscr[7:0], "regs_rddata VSCR_LO");
        check_readback(4'd9, {4'h0, rw.vscr[11:8]}, "regs_rddata VSCR_HI");
        check_readback(4'd12, 8'h00, "regs_rddata unused");
        chk.compare_enable(rw.ctrl0_exp[0]);
        chk.start_line(rw.ctrl0_exp[7:5], rw.ctrl1_wr[3:0], rw.map_base, rw.tile_base,
                       rw.hscr[11:0], rw.vscr[11:0], rw.line);
        @(posedge clk);
        #2;
        line_idx          = rw.line;
        line_render_start = 1'b1;
        @(posedge clk);
        #2;
        line_render_start = 1'b0;
        @(negedge clk);
        while (line_render_done !== 1'b1)
            @(negedge clk);
        chk.finish_line();
        chk.close_test($sformatf("line test %0d mode %0d", r, rw.ctrl0_exp[7:5]));
    endtask

    initial begin
        void'($urandom(32'h718a));
        for (int i = 0; i < 65536; i++)
            mem[i] = $urandom;
        rst               = 1'b1;
        line_idx          = '0;
        line_render_start = 1'b0;
        regs_addr         = '0;
        regs_wrdata       = '0;
        regs_write        = 1'b0;

        // ctrl0, ctrl0 readback, ctrl1, map, tile, hscroll, vscroll, line
        rows[0] = '{8'hF5, 8'hE1, 8'h00, 16'h1000, 16'h2000, 16'h0A03, 16'h0000, 9'd5};
        rows[1] = '{8'hC1, 8'hC1, 8'h00, 16'h0000, 16'h4000, 16'h0500, 16'h0000, 9'd100};
        rows[2] = '{8'hA1, 8'hA1, 8'h03, 16'h0000, 16'hC000, 16'hF307, 16'h0000, 9'd479};
        rows[3] = '{8'h41, 8'h41, 8'h00, 16'h0100, 16'h8000, 16'h0000, 16'h0000, 9'd0};
        rows[4] = '{8'h61, 8'h61, 8'h05, 16'h3000, 16'h5000, 16'h0013, 16'h0021, 9'd37};
        rows[5] = '{8'h81, 8'h81, 8'hFA, 16'hFF00, 16'h6000, 16'h02FD, 16'h03F5, 9'd200};
        rows[6] = '{8'h21, 8'h41, 8'h0F, 16'h7000, 16'h9000, 16'h07FF, 16'h0FFF, 9'd300};
        rows[7] = '{8'h00, 8'h40, 8'h06, 16'hA000, 16'hB000, 16'h0105, 16'h0410, 9'd511};
        rows[8] = '{8'h7F, 8'h61, 8'h09, 16'h0800, 16'hE000, 16'h0E6E, 16'h0707, 9'd64};

        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;

        ////////////////////
        // Reset state
        ////////////////////
        @(negedge clk);
        chk.check_outputs_low();
        check_readback(4'd0, 8'h40, "regs_rddata CTRL0");
        check_readback(4'd1, 8'h00, "regs_rddata CTRL1");
        check_readback(4'd2, 8'h00, "regs_rddata MAP_LO");
        check_readback(4'd3, 8'h00, "regs_rddata MAP_HI");
        check_readback(4'd4, 8'h00, "regs_rddata TILE_LO");
        check_readback(4'd5, 8'h80, "regs_rddata TILE_HI");
        check_readback(4'd6, 8'h00, "regs_rddata HSCR_LO");
        check_readback(4'd7, 8'h00, "regs_rddata HSCR_HI");
        check_readback(4'd8, 8'h00, "regs_rddata VSCR_LO");
        check_readback(4'd9, 8'h00, "regs_rddata VSCR_HI");
        chk.close_test("reset state");

        for (int r = 0; r < NUM_ROWS; r++)
            render_row(r);

        chk.print_counts();
        if (chk.errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

// ==== layer_renderer.f ====
design/layer_cfg_pkg.sv
design/layer_bus_pkg.sv
design/layer_regs.sv
design/layer_addr_gen.sv
design/layer_fetch.sv
design/layer_pixel_out.sv
design/layer_renderer.sv
bench/layer_checker.sv
bench/tb_layer_renderer.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the layer renderer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_layer_renderer \
    -f layer_renderer.f \
    -o sim_layer_renderer

out=$(./obj_dir/sim_layer_renderer)
echo "$out"
echo "$out" | grep -qx "Test OK"
